// ==== hw/max_pool_pkg.sv ====
`default_nettype none

package max_pool_pkg;

	// byte offsets of the AXI4-Lite register map
	localparam logic [11:0] reg_ctrl_addr   = 12'h000; // bit0 starts a run
	localparam logic [11:0] reg_status_addr = 12'h004; // bit0 idle, bit1 done
	localparam logic [11:0] reg_width_addr  = 12'h008;
	localparam logic [11:0] reg_height_addr = 12'h00C;
	localparam logic [11:0] reg_chn_addr    = 12'h010;
	localparam logic [11:0] reg_itr_en_addr = 12'h014; // bit0 enables itr

	// the slave never reports an error
	localparam logic [1:0] resp_okay = 2'b00;

	// geometry fields are kept as size minus one
	localparam int dim_width = 16;

	typedef logic [dim_width-1:0] dim_t;

endpackage

`default_nettype wire

// ==== hw/pool_row_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

// one row of horizontal pair maxima, written in even rows
// and read back while the following odd row streams in
module pool_row_buf #(
	parameter int data_width = 16,
	parameter int depth      = 32,
	localparam int addr_width = $clog2(depth)
) (
	input  wire                   clk,
	input  wire                   wr_en,
	input  wire [addr_width-1:0]  wr_addr,
	input  wire [data_width-1:0]  wr_data,
	input  wire [addr_width-1:0]  rd_addr,
	output logic [data_width-1:0] rd_data
);

	logic [data_width-1:0] mem [depth];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hw/pool_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_core #(
	parameter int data_width    = 16,
	parameter int max_feature_w = 64
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       cal_start,
	output wire                       cal_idle,
	output logic                      cal_done,
	input  wire max_pool_pkg::dim_t   feature_w,
	input  wire max_pool_pkg::dim_t   feature_h,
	input  wire max_pool_pkg::dim_t   feature_chn,
	input  wire [data_width-1:0]      s_axis_data,
	input  wire                       s_axis_valid,
	output wire                       s_axis_ready,
	output logic [data_width:0]       res_payload, // {last, pixel}
	output logic                      res_valid,
	input  wire                       res_ready
);
	import max_pool_pkg::*;

	localparam int buf_depth = max_feature_w / 2;
	localparam int buf_aw    = $clog2(buf_depth);

	logic                  busy;
	logic                  feed_done;   // final pixel already taken
	dim_t                  x_cnt;
	dim_t                  y_cnt;
	dim_t                  c_cnt;
	logic                  pix_fire;
	logic                  pair_end;
	logic                  row_end;
	logic                  col_end;
	logic                  pix_last;
	logic                  res_issue;
	logic                  last_taken;
	logic                  buf_wr;
	logic [buf_aw-1:0]     buf_addr;
	logic [data_width-1:0] buf_rd_data;
	logic [data_width-1:0] pix_first;
	logic [data_width-1:0] pair_max;
	logic [data_width-1:0] win_max;

	assign cal_idle     = ~busy;
	assign s_axis_ready = busy & ~feed_done & res_ready;
	assign pix_fire     = s_axis_valid & s_axis_ready;
	assign pair_end     = x_cnt[0]; // odd column closes a pair
	assign row_end      = x_cnt == feature_w;
	assign col_end      = y_cnt == feature_h;
	assign pix_last     = row_end & col_end & (c_cnt == feature_chn);
	assign buf_addr     = x_cnt[buf_aw:1];
	assign buf_wr       = pix_fire & pair_end & ~y_cnt[0];
	assign res_issue    = pix_fire & pair_end & y_cnt[0];
	assign last_taken   = res_valid & res_ready & res_payload[data_width];

	// unsigned pixel compare
	assign pair_max = (s_axis_data > pix_first) ? s_axis_data : pix_first;
	assign win_max  = (buf_rd_data > pair_max) ? buf_rd_data : pair_max;

	// buf_addr is steady for a whole pair, so rd_data is ready by its second pixel
	pool_row_buf #(
		.data_width(data_width),
		.depth(buf_depth)
	) u_row_buf (
		.clk(clk),
		.wr_en(buf_wr),
		.wr_addr(buf_addr),
		.wr_data(pair_max),
		.rd_addr(buf_addr),
		.rd_data(buf_rd_data)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			feed_done <= 1'b0;
			cal_done  <= 1'b0;
			x_cnt     <= '0;
			y_cnt     <= '0;
			c_cnt     <= '0;
		end else begin
			cal_done <= last_taken;
			if (cal_start && !busy) begin
				busy      <= 1'b1;
				feed_done <= 1'b0;
				x_cnt     <= '0;
				y_cnt     <= '0;
				c_cnt     <= '0;
			end else begin
				if (last_taken) begin
					busy <= 1'b0;
				end
				if (pix_fire) begin
					if (pix_last) begin
						feed_done <= 1'b1;
					end
					if (row_end) begin
						x_cnt <= '0;
						if (col_end) begin
							y_cnt <= '0;
							c_cnt <= c_cnt + dim_t'(1); // next channel
						end else begin
							y_cnt <= y_cnt + dim_t'(1);
						end
					end else begin
						x_cnt <= x_cnt + dim_t'(1);
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pix_fire && !pair_end) begin
			pix_first <= s_axis_data;
		end
		if (res_issue) begin
			res_payload <= {pix_last, win_max};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= res_issue; // one cycle, slice always has room
		end
	end

	// relies on the slice keeping a free entry for the cycle after a pixel
	res_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> res_ready);

endmodule

`default_nettype wire

// ==== hw/axis_reg_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_reg_slice #(
	parameter type payload_t = logic [15:0]
) (
	input  wire           clk,
	input  wire           rst_n,
	input  wire payload_t s_payload,
	input  wire           s_valid,
	output wire           s_ready,
	output payload_t      m_payload,
	output logic          m_valid,
	input  wire           m_ready
);

	payload_t skid_payload;
	logic     skid_valid; // second entry in use

	assign s_ready = ~skid_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_valid    <= 1'b0;
			skid_valid <= 1'b0;
		end else if (skid_valid) begin
			if (m_ready) begin
				skid_valid <= 1'b0; // skid moves to the output
			end
		end else if (s_valid && m_valid && !m_ready) begin
			skid_valid <= 1'b1;
		end else if (s_valid) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (skid_valid) begin
			if (m_ready) begin
				m_payload <= skid_payload;
			end
		end else if (s_valid) begin
			if (m_valid && !m_ready) begin
				skid_payload <= s_payload;
			end else begin
				m_payload <= s_payload;
			end
		end
	end

	m_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_payload));

endmodule

`default_nettype wire

// ==== hw/pool_reg_if.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_reg_if (
	input  wire                       clk,
	input  wire                       rst_n,
	// AXI4-Lite slave
	input  wire [11:0]                s_axi_awaddr,
	input  wire                       s_axi_awvalid,
	output logic                      s_axi_awready,
	input  wire [31:0]                s_axi_wdata,
	input  wire                       s_axi_wvalid,
	output wire                       s_axi_wready,
	output wire [1:0]                 s_axi_bresp,
	output logic                      s_axi_bvalid,
	input  wire                       s_axi_bready,
	input  wire [11:0]                s_axi_araddr,
	input  wire                       s_axi_arvalid,
	output wire                       s_axi_arready,
	output logic [31:0]               s_axi_rdata,
	output wire [1:0]                 s_axi_rresp,
	output logic                      s_axi_rvalid,
	input  wire                       s_axi_rready,
	// pooling core control
	output logic                      cal_start,
	input  wire                       cal_idle,
	input  wire                       cal_done,
	output max_pool_pkg::dim_t        feature_w,
	output max_pool_pkg::dim_t        feature_h,
	output max_pool_pkg::dim_t        feature_chn,
	output wire                       itr
);
	import max_pool_pkg::*;

	logic        wr_fire;
	logic        rd_fire;
	logic        done;
	logic        itr_en;
	logic [31:0] rd_mux;

	assign wr_fire       = s_axi_awready & s_axi_awvalid & s_axi_wvalid;
	assign rd_fire       = s_axi_arvalid & s_axi_arready;
	assign s_axi_wready  = s_axi_awready; // address and data taken in the same cycle
	assign s_axi_arready = ~s_axi_rvalid; // one read in flight at most
	assign s_axi_bresp   = resp_okay;
	assign s_axi_rresp   = resp_okay;
	assign itr           = done & itr_en;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axi_awready <= 1'b0;
			s_axi_bvalid  <= 1'b0;
		end else begin
			// single cycle pulse, never while a response waits
			s_axi_awready <= s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
			if (wr_fire) begin
				s_axi_bvalid <= 1'b1;
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cal_start   <= 1'b0;
			feature_w   <= '0;
			feature_h   <= '0;
			feature_chn <= '0;
			itr_en      <= 1'b0;
		end else begin
			cal_start <= wr_fire && s_axi_awaddr == reg_ctrl_addr && s_axi_wdata[0] && cal_idle;
			if (wr_fire) begin
				case (s_axi_awaddr)
					reg_width_addr:  feature_w   <= s_axi_wdata[dim_width-1:0];
					reg_height_addr: feature_h   <= s_axi_wdata[dim_width-1:0];
					reg_chn_addr:    feature_chn <= s_axi_wdata[dim_width-1:0];
					reg_itr_en_addr: itr_en      <= s_axi_wdata[0];
					default: ;
				endcase
			end
		end
	end

	// sticky done, write 1 to clear; a new completion wins over the clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else if (cal_done) begin
			done <= 1'b1;
		end else if (wr_fire && s_axi_awaddr == reg_status_addr && s_axi_wdata[1]) begin
			done <= 1'b0;
		end
	end

	always_comb begin
		rd_mux = '0; // ctrl and unmapped offsets read as zero
		case (s_axi_araddr)
			reg_status_addr: rd_mux[1:0]           = {done, cal_idle};
			reg_width_addr:  rd_mux[dim_width-1:0] = feature_w;
			reg_height_addr: rd_mux[dim_width-1:0] = feature_h;
			reg_chn_addr:    rd_mux[dim_width-1:0] = feature_chn;
			reg_itr_en_addr: rd_mux[0]             = itr_en;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			s_axi_rdata <= rd_mux;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axi_rvalid <= 1'b0;
		end else if (rd_fire) begin
			s_axi_rvalid <= 1'b1;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

	// core drops idle right after the pulse, so no second start follows
	start_single: assert property (@(posedge clk) disable iff (!rst_n)
		cal_start |=> !cal_start);

endmodule

`default_nettype wire

// ==== hw/axi_max_pool.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_max_pool #(
	parameter int data_width    = 16,
	parameter int max_feature_w = 64
) (
	input  wire                  clk,
	input  wire                  rst_n,
	// register port
	input  wire [11:0]           s_axi_awaddr,
	input  wire                  s_axi_awvalid,
	output wire                  s_axi_awready,
	input  wire [31:0]           s_axi_wdata,
	input  wire                  s_axi_wvalid,
	output wire                  s_axi_wready,
	output wire [1:0]            s_axi_bresp,
	output wire                  s_axi_bvalid,
	input  wire                  s_axi_bready,
	input  wire [11:0]           s_axi_araddr,
	input  wire                  s_axi_arvalid,
	output wire                  s_axi_arready,
	output wire [31:0]           s_axi_rdata,
	output wire [1:0]            s_axi_rresp,
	output wire                  s_axi_rvalid,
	input  wire                  s_axi_rready,
	// pixel streams
	input  wire [data_width-1:0] s_axis_data,
	input  wire                  s_axis_valid,
	output wire                  s_axis_ready,
	output wire [data_width-1:0] m_axis_data,
	output wire                  m_axis_last,
	output wire                  m_axis_valid,
	input  wire                  m_axis_ready,
	output wire                  itr
);
	import max_pool_pkg::*;

	typedef struct packed {
		logic                  last;
		logic [data_width-1:0] data;
	} pool_res_t;

	logic      cal_start;
	logic      cal_idle;
	logic      cal_done;
	dim_t      feature_w;
	dim_t      feature_h;
	dim_t      feature_chn;
	pool_res_t res_payload;
	pool_res_t out_payload;
	logic      res_valid;
	logic      res_ready;

	assign m_axis_data = out_payload.data;
	assign m_axis_last = out_payload.last;

	pool_reg_if u_reg_if (
		.clk(clk), .rst_n(rst_n),
		.s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
		.s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp), .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready), .s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp), .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
		.cal_start(cal_start), .cal_idle(cal_idle), .cal_done(cal_done),
		.feature_w(feature_w), .feature_h(feature_h), .feature_chn(feature_chn),
		.itr(itr)
	);

	pool_core #(
		.data_width(data_width),
		.max_feature_w(max_feature_w)
	) u_core (
		.clk(clk), .rst_n(rst_n),
		.cal_start(cal_start), .cal_idle(cal_idle), .cal_done(cal_done),
		.feature_w(feature_w), .feature_h(feature_h), .feature_chn(feature_chn),
		.s_axis_data(s_axis_data), .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready),
		.res_payload(res_payload), .res_valid(res_valid), .res_ready(res_ready)
	);

	// output slice decouples the core from downstream stalls
	axis_reg_slice #(
		.payload_t(pool_res_t)
	) u_out_slice (
		.clk(clk), .rst_n(rst_n),
		.s_payload(res_payload), .s_valid(res_valid), .s_ready(res_ready),
		.m_payload(out_payload), .m_valid(m_axis_valid), .m_ready(m_axis_ready)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int period_ns    = 8,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst_n
);

	localparam int half_period = period_ns / 2;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/tb_axi_max_pool.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axi_max_pool;

	localparam logic [11:0] ctrl_addr   = 12'h000;
	localparam logic [11:0] status_addr = 12'h004;
	localparam logic [11:0] width_addr  = 12'h008;
	localparam logic [11:0] height_addr = 12'h00C;
	localparam logic [11:0] chn_addr    = 12'h010;
	localparam logic [11:0] itr_en_addr = 12'h014;

	wire         clk;
	wire         rst_n;
	logic [11:0] s_axi_awaddr;
	logic        s_axi_awvalid;
	wire         s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic        s_axi_wvalid;
	wire         s_axi_wready;
	wire [1:0]   s_axi_bresp;
	wire         s_axi_bvalid;
	logic        s_axi_bready;
	logic [11:0] s_axi_araddr;
	logic        s_axi_arvalid;
	wire         s_axi_arready;
	wire [31:0]  s_axi_rdata;
	wire [1:0]   s_axi_rresp;
	wire         s_axi_rvalid;
	logic        s_axi_rready;
	logic [15:0] s_axis_data;
	logic        s_axis_valid;
	wire         s_axis_ready;
	wire [15:0]  m_axis_data;
	wire         m_axis_last;
	wire         m_axis_valid;
	logic        m_axis_ready;
	wire         itr;

	logic [15:0] in_q[$];
	logic [15:0] exp_q[$];
	int          case_w[$];
	int          case_h[$];
	int          case_c[$];
	logic [15:0] feed_lfsr = 16'd8;
	logic [15:0] sink_lfsr = 16'd8;
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycles = 0;
	int          limit = 2000;
	int          p_in;
	int          p_out;

	tb_clk_gen #(.period_ns(8), .reset_cycles(5)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	axi_max_pool #(.data_width(16), .max_feature_w(64)) u_dut (.*);

	// galois form, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
		@(negedge clk);
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		do @(posedge clk); while (!(s_axi_awready && s_axi_wready));
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		do @(posedge clk); while (!s_axi_bvalid); // bready stays high
		check_value("s_axi_bresp", 32'(s_axi_bresp), 32'h0);
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
		@(negedge clk);
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		do @(posedge clk); while (!s_axi_arready);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		do @(posedge clk); while (!s_axi_rvalid);
		data = s_axi_rdata;
		check_value("s_axi_rresp", 32'(s_axi_rresp), 32'h0);
	endtask

	task automatic load_patterns();
		int          fd;
		int          w;
		int          h;
		int          c;
		int          n;
		logic [15:0] v;
		string       line;
		fd = $fopen("bench/pool_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/pool_patterns.txt");
			other_errors++;
			return;
		end
		repeat (2) begin
			if ($fgets(line, fd) == 0 || line.len() == 0 || line[0] != 8'h23) begin
				$display("pattern file does not start with its two header lines");
				other_errors++;
			end
		end
		while ($fscanf(fd, "%d %d %d", w, h, c) == 3) begin
			n = w * h * c;
			case_w.push_back(w);
			case_h.push_back(h);
			case_c.push_back(c);
			for (int i = 0; i < n + n / 4; i++) begin
				if ($fscanf(fd, "%h", v) != 1) begin
					$display("pattern file ends inside case %0d", case_w.size());
					other_errors++;
					break;
				end
				if (i < n) in_q.push_back(v); // inputs first, then expected
				else exp_q.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	task automatic feed_pixels(input int first, input int count);
		int idx;
		idx = first;
		while (idx < first + count) begin
			@(negedge clk);
			feed_lfsr    = lfsr_step(feed_lfsr);
			s_axis_valid = !feed_lfsr[0]; // random gap on a one
			s_axis_data  = in_q[idx];
			@(posedge clk);
			if (s_axis_valid && s_axis_ready) idx++;
		end
		@(negedge clk);
		s_axis_valid = 1'b0;
	endtask

	task automatic collect_results(input int first, input int count);
		int   n;
		logic a;
		logic b;
		n = 0;
		while (n < count) begin
			@(negedge clk);
			sink_lfsr    = lfsr_step(sink_lfsr);
			a            = sink_lfsr[0];
			sink_lfsr    = lfsr_step(sink_lfsr);
			b            = sink_lfsr[0];
			m_axis_ready = !(a && b); // stall one cycle in four
			@(posedge clk);
			if (m_axis_valid && m_axis_ready) begin
				check_value("m_axis_data", 32'(m_axis_data), 32'(exp_q[first + n]));
				check_value("m_axis_last", 32'(m_axis_last), 32'(n == count - 1));
				n++;
			end
		end
		@(negedge clk);
		m_axis_ready = 1'b0;
	endtask

	task automatic check_registers();
		logic [31:0] rd;
		axi_read(ctrl_addr, rd);
		check_value("ctrl", rd, 32'h0);
		axi_read(status_addr, rd);
		check_value("status", rd, 32'h1); // idle only
		axi_read(width_addr, rd);
		check_value("width", rd, 32'h0);
		axi_read(height_addr, rd);
		check_value("height", rd, 32'h0);
		axi_read(chn_addr, rd);
		check_value("chn", rd, 32'h0);
		axi_read(itr_en_addr, rd);
		check_value("itr_en", rd, 32'h0);
		check_value("itr", 32'(itr), 32'h0);
		axi_write(width_addr, 32'h0000_0a5c);
		axi_write(height_addr, 32'h0000_0137);
		axi_write(chn_addr, 32'h0000_00ff);
		axi_read(width_addr, rd);
		check_value("width", rd, 32'h0a5c);
		axi_read(height_addr, rd);
		check_value("height", rd, 32'h0137);
		axi_read(chn_addr, rd);
		check_value("chn", rd, 32'h00ff);
		axi_read(12'h018, rd);
		check_value("unmapped 0x018", rd, 32'h0);
	endtask

	task automatic run_case(input int k, input int first_in, input int first_out);
		int          n_in;
		logic        en;
		logic [31:0] rd;
		n_in = case_w[k] * case_h[k] * case_c[k];
		en   = (k % 2) == 0;
		axi_write(width_addr, 32'(case_w[k] - 1));
		axi_write(height_addr, 32'(case_h[k] - 1));
		axi_write(chn_addr, 32'(case_c[k] - 1));
		axi_write(itr_en_addr, 32'(en));
		axi_write(ctrl_addr, 32'h1);
		fork
			feed_pixels(first_in, n_in);
			collect_results(first_out, n_in / 4);
		join
		do axi_read(status_addr, rd); while (!rd[1]);
		check_value("status", rd, 32'h3);
		@(negedge clk);
		check_value("itr", 32'(itr), 32'(en));
		check_value("m_axis_valid", 32'(m_axis_valid), 32'h0); // nothing extra pending
		check_value("s_axis_ready", 32'(s_axis_ready), 32'h0);
		axi_write(status_addr, 32'h2);
		axi_read(status_addr, rd);
		check_value("status", rd, 32'h1);
		@(negedge clk);
		check_value("itr", 32'(itr), 32'h0);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b1;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b1;
		s_axis_data   = '0;
		s_axis_valid  = 1'b0;
		m_axis_ready  = 1'b0;
		load_patterns();
		limit = 4 * in_q.size() + 2000;
		wait (rst_n === 1'b1);
		check_registers();
		p_in  = 0;
		p_out = 0;
		for (int k = 0; k < case_w.size(); k++) begin
			run_case(k, p_in, p_out);
			p_in  += case_w[k] * case_h[k] * case_c[k];
			p_out += case_w[k] * case_h[k] * case_c[k] / 4;
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/pool_patterns.txt ====
# each case: width height channels (decimal), then width*height*channels input pixels
# in stream order, then the pooled pixels in output order; all pixels in hex
4 4 1
0003 0011 0007 0002
0005 0001 0020 0008
00ff 0010 0000 0001
0004 0100 0002 0003
0011 0020 0100 0003
2 2 2
1234 0abc ffff 0000
8000 7fff 8001 0002
ffff 8001
6 2 1
0010 0020 0030 0005 0001 0002
0015 0001 0004 0031 0009 0003
0020 0031 0009

// ==== axi_max_pool.f ====
hw/max_pool_pkg.sv
hw/pool_row_buf.sv
hw/pool_core.sv
hw/axis_reg_slice.sv
hw/pool_reg_if.sv
hw/axi_max_pool.sv
bench/tb_clk_gen.sv
bench/tb_axi_max_pool.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wall --top-module tb_axi_max_pool -f axi_max_pool.f
	./obj_dir/Vtb_axi_max_pool | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
